/* rv_mem_pkg.sv */
// Shared types and constants for the RV32I data-memory subsystem
// The bus is always little-endian and there are no access faults
// RAM depth is fixed, byte addresses wrap modulo the RAM size
package rv_mem_pkg;

  // Data or address word
  typedef logic [31:0] word_t;

  // I-type layout, used to decode loads
  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_type_t;

  // S-type layout, used to decode stores
  // Immediate is split around rs2/rs1/funct3
  typedef struct packed {
    logic [6:0]  imm_hi;
    logic [4:0]  rs2;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  imm_lo;
    logic [6:0]  opcode;
  } s_type_t;

  // Same instruction word seen two ways
  // funct3 and opcode sit at the same bits in both views
  typedef union packed {
    i_type_t i_view;
    s_type_t s_view;
  } instr_t;

  // Major opcodes
  localparam logic [6:0] OPC_LOAD  = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;

  // funct3 width codes, stores reuse LB/LH/LW
  localparam logic [2:0] LB  = 3'b000;
  localparam logic [2:0] LH  = 3'b001;
  localparam logic [2:0] LW  = 3'b010;
  localparam logic [2:0] LBU = 3'b100;
  localparam logic [2:0] LHU = 3'b101;

  // Data RAM geometry
  localparam int MEM_WORDS = 256;
  localparam int MEM_AW    = 8;

endpackage

/* data_ram.sv */
// Byte-enabled single-port word RAM
// Reads are registered, data shows up one cycle after ram_en
// A write updates only the enabled byte lanes at the clock edge
// No access is taken while rst_n is low; contents are not cleared
`timescale 1ns/1ps

module data_ram (
  input  logic                            CLK,
  input  logic                            rst_n,
  input  logic                            ram_en,
  input  logic                            ram_we,
  input  logic [rv_mem_pkg::MEM_AW-1:0]   ram_addr,
  input  logic [3:0]                      ram_byte_en,
  input  rv_mem_pkg::word_t               ram_wdata,
  output rv_mem_pkg::word_t               ram_rdata
);

  // Word storage
  rv_mem_pkg::word_t mem [rv_mem_pkg::MEM_WORDS];

  // Port is idle while the subsystem is held in reset
  logic access;
  assign access = rst_n & ram_en;

  always_ff @(posedge CLK) begin
    if (access) begin
      if (ram_we) begin
        // Lane i maps to byte address offset i
        for (int i = 0; i < 4; i++) begin
          if (ram_byte_en[i]) begin
            mem[ram_addr][i*8 +: 8] <= ram_wdata[i*8 +: 8];
          end
        end
      end else begin
        ram_rdata <= mem[ram_addr];
      end
    end
  end

  // A write with no lanes enabled means the requester decoded badly
  assert property (@(posedge CLK) disable iff (!rst_n)
    (ram_en && ram_we) |-> (ram_byte_en != 4'b0000));

endmodule

/* mem_arbiter.sv */
// Round-robin arbiter between the load/store unit and instruction fetch
// Grants are combinational; a requester holds req until it sees its grant
// Read data returns one cycle after the grant with a valid for the owner
// Only the load/store side writes; fetch always reads whole words
`timescale 1ns/1ps

module mem_arbiter (
  input  logic                            CLK,
  input  logic                            rst_n,
  input  logic                            lsu_req,
  input  logic                            lsu_we,
  input  rv_mem_pkg::word_t               lsu_addr,
  input  logic [3:0]                      lsu_byte_en,
  input  rv_mem_pkg::word_t               lsu_wdata,
  input  logic                            fetch_req,
  input  rv_mem_pkg::word_t               fetch_addr,
  input  rv_mem_pkg::word_t               ram_rdata,
  output logic                            lsu_gnt,
  output logic                            fetch_gnt,
  output logic                            lsu_rvalid,
  output logic                            fetch_rvalid,
  output rv_mem_pkg::word_t               rdata,
  output logic                            ram_en,
  output logic                            ram_we,
  output logic [rv_mem_pkg::MEM_AW-1:0]   ram_addr,
  output logic [3:0]                      ram_byte_en,
  output rv_mem_pkg::word_t               ram_wdata
);

  // High when the load/store unit won the most recent grant
  logic last_lsu;

  // On conflict the peer that did not win last time goes first
  assign lsu_gnt   = lsu_req & (~fetch_req | ~last_lsu);
  assign fetch_gnt = fetch_req & (~lsu_req | last_lsu);

  // RAM port steering
  assign ram_en      = lsu_gnt | fetch_gnt;
  assign ram_we      = lsu_gnt & lsu_we;
  assign ram_byte_en = lsu_gnt ? lsu_byte_en : 4'b1111;
  assign ram_wdata   = lsu_wdata;

  // Byte address to word index, upper bits wrap
  always_comb begin
    if (lsu_gnt) begin
      ram_addr = lsu_addr[rv_mem_pkg::MEM_AW+1:2];
    end else begin
      ram_addr = fetch_addr[rv_mem_pkg::MEM_AW+1:2];
    end
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      last_lsu     <= 1'b0;
      lsu_rvalid   <= 1'b0;
      fetch_rvalid <= 1'b0;
    end else begin
      if (lsu_gnt) begin
        last_lsu <= 1'b1;
      end else if (fetch_gnt) begin
        last_lsu <= 1'b0;
      end
      // Owner of the read in flight, stores return nothing
      lsu_rvalid   <= lsu_gnt & ~lsu_we;
      fetch_rvalid <= fetch_gnt;
    end
  end

  // Shared return bus, qualified by the rvalid pulses
  assign rdata = ram_rdata;

  assert property (@(posedge CLK) disable iff (!rst_n) !(lsu_gnt && fetch_gnt));

endmodule

/* load_store_unit.sv */
// RV32I load/store unit for a little-endian word bus
// Accepts one access per mem_req pulse; mem_req must not come while lsu_busy
// Misaligned or illegal accesses pulse an exception one cycle later, no bus access
// Loads finish with load_valid, stores with store_done
// Only OPC_LOAD and OPC_STORE are decoded, any other opcode is illegal
`timescale 1ns/1ps

module load_store_unit (
  input  logic                  CLK,
  input  logic                  rst_n,
  input  logic                  mem_req,
  input  rv_mem_pkg::instr_t    instr,
  input  rv_mem_pkg::word_t     rs1_data,
  input  rv_mem_pkg::word_t     rs2_data,
  input  logic                  lsu_gnt,
  input  logic                  lsu_rvalid,
  input  rv_mem_pkg::word_t     rdata,
  output logic                  lsu_req,
  output logic                  lsu_we,
  output rv_mem_pkg::word_t     lsu_addr,
  output logic [3:0]            lsu_byte_en,
  output rv_mem_pkg::word_t     lsu_wdata,
  output logic                  lsu_busy,
  output rv_mem_pkg::word_t     load_data,
  output logic                  load_valid,
  output logic                  store_done,
  output logic                  mal_l,
  output logic                  mal_s,
  output logic                  illegal
);

  // Decode of the incoming instruction
  logic              is_load;
  logic              is_store;
  logic [2:0]        width;
  logic              width_ok;
  logic              bad_op;
  logic              misaligned;
  rv_mem_pkg::word_t imm_ext;
  rv_mem_pkg::word_t eff_addr;
  logic [1:0]        offset;
  logic [3:0]        byte_en;
  rv_mem_pkg::word_t store_data;
  logic              accept;

  // Access state and captured load attributes
  logic              wait_r;
  logic [2:0]        acc_width;
  logic [1:0]        acc_off;
  rv_mem_pkg::word_t shifted;
  rv_mem_pkg::word_t load_ext;

  // funct3 and opcode share bit positions in both views
  assign is_load  = (instr.i_view.opcode == rv_mem_pkg::OPC_LOAD);
  assign is_store = (instr.s_view.opcode == rv_mem_pkg::OPC_STORE);
  assign width    = instr.i_view.funct3;

  // Stores have no unsigned forms
  always_comb begin
    case (width)
      rv_mem_pkg::LB, rv_mem_pkg::LH, rv_mem_pkg::LW: width_ok = is_load | is_store;
      rv_mem_pkg::LBU, rv_mem_pkg::LHU:               width_ok = is_load;
      default:                                        width_ok = 1'b0;
    endcase
  end
  assign bad_op = ~width_ok;

  // Immediate comes from the I view for loads, the S view for stores
  assign imm_ext = is_store ?
                   {{20{instr.s_view.imm_hi[6]}}, instr.s_view.imm_hi, instr.s_view.imm_lo} :
                   {{20{instr.i_view.imm[11]}}, instr.i_view.imm};

  assign eff_addr = rs1_data + imm_ext;
  assign offset   = eff_addr[1:0];

  // Lane selection, byte 0 is the lowest address
  always_comb begin
    case (width)
      rv_mem_pkg::LB, rv_mem_pkg::LBU: byte_en = 4'b0001 << offset;
      rv_mem_pkg::LH, rv_mem_pkg::LHU: byte_en = offset[1] ? 4'b1100 : 4'b0011;
      rv_mem_pkg::LW:                  byte_en = 4'b1111;
      default:                         byte_en = 4'b0000;
    endcase
  end

  // Halves need even offsets, words need offset zero
  always_comb begin
    case (width)
      rv_mem_pkg::LH, rv_mem_pkg::LHU: misaligned = offset[0];
      rv_mem_pkg::LW:                  misaligned = (offset != 2'b00);
      default:                         misaligned = 1'b0;
    endcase
  end

  // Replicate so the right lane carries the data whatever the offset
  always_comb begin
    case (width)
      rv_mem_pkg::LB: store_data = {4{rs2_data[7:0]}};
      rv_mem_pkg::LH: store_data = {2{rs2_data[15:0]}};
      default:        store_data = rs2_data;
    endcase
  end

  assign lsu_busy = lsu_req | wait_r;
  assign accept   = mem_req & ~lsu_busy;

  // Control state
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      lsu_req    <= 1'b0;
      wait_r     <= 1'b0;
      load_valid <= 1'b0;
      store_done <= 1'b0;
      mal_l      <= 1'b0;
      mal_s      <= 1'b0;
      illegal    <= 1'b0;
    end else begin
      load_valid <= 1'b0;
      store_done <= 1'b0;
      // Exceptions replace the bus request
      illegal <= accept & bad_op;
      mal_l   <= accept & ~bad_op & is_load & misaligned;
      mal_s   <= accept & ~bad_op & is_store & misaligned;
      if (accept && !bad_op && !misaligned) begin
        lsu_req <= 1'b1;
      end
      if (lsu_req && lsu_gnt) begin
        lsu_req <= 1'b0;
        if (lsu_we) begin
          store_done <= 1'b1;
        end else begin
          wait_r <= 1'b1;
        end
      end
      if (wait_r && lsu_rvalid) begin
        wait_r     <= 1'b0;
        load_valid <= 1'b1;
      end
    end
  end

  // Request payload, held while lsu_req is high
  always_ff @(posedge CLK) begin
    if (accept) begin
      lsu_we      <= is_store;
      lsu_addr    <= eff_addr;
      lsu_byte_en <= byte_en;
      lsu_wdata   <= store_data;
      acc_width   <= width;
      acc_off     <= offset;
    end
    if (wait_r && lsu_rvalid) begin
      load_data <= load_ext;
    end
  end

  // Bring the addressed byte or half down to bit 0, then extend
  assign shifted = rdata >> {acc_off, 3'b000};

  always_comb begin
    case (acc_width)
      rv_mem_pkg::LB:  load_ext = {{24{shifted[7]}}, shifted[7:0]};
      rv_mem_pkg::LBU: load_ext = {24'h000000, shifted[7:0]};
      rv_mem_pkg::LH:  load_ext = {{16{shifted[15]}}, shifted[15:0]};
      rv_mem_pkg::LHU: load_ext = {16'h0000, shifted[15:0]};
      default:         load_ext = rdata;
    endcase
  end

  // Callers wait for the previous access to finish
  assert property (@(posedge CLK) disable iff (!rst_n) mem_req |-> !lsu_busy);

endmodule

/* fetch_unit.sv */
// Sequential instruction fetch with redirect, one read in flight
// fetch_req and redirect must not come while fetch_busy is high
// A redirect together with fetch_req fetches from the new target
// Targets are forced to word alignment
`timescale 1ns/1ps

module fetch_unit (
  input  logic                  CLK,
  input  logic                  rst_n,
  input  logic                  fetch_req,
  input  logic                  redirect,
  input  rv_mem_pkg::word_t     redirect_addr,
  input  logic                  fetch_gnt,
  input  logic                  fetch_rvalid,
  input  rv_mem_pkg::word_t     rdata,
  output logic                  fetch_req_bus,
  output rv_mem_pkg::word_t     fetch_addr,
  output logic                  fetch_busy,
  output rv_mem_pkg::word_t     fetch_instr,
  output rv_mem_pkg::word_t     fetch_pc,
  output logic                  fetch_valid
);

  rv_mem_pkg::word_t pc;
  rv_mem_pkg::word_t next_pc;
  logic              wait_r;

  // Redirect wins over the current PC in the same cycle
  assign next_pc    = redirect ? {redirect_addr[31:2], 2'b00} : pc;
  assign fetch_busy = fetch_req_bus | wait_r;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      pc            <= '0;
      fetch_req_bus <= 1'b0;
      wait_r        <= 1'b0;
      fetch_valid   <= 1'b0;
    end else begin
      fetch_valid <= 1'b0;
      if (redirect) begin
        pc <= next_pc;
      end
      if (fetch_req) begin
        fetch_req_bus <= 1'b1;
      end
      if (fetch_req_bus && fetch_gnt) begin
        fetch_req_bus <= 1'b0;
        wait_r        <= 1'b1;
      end
      // Word arrives, step to the next sequential address
      if (wait_r && fetch_rvalid) begin
        wait_r      <= 1'b0;
        fetch_valid <= 1'b1;
        pc          <= fetch_addr + 32'd4;
      end
    end
  end

  // Address and returned word
  always_ff @(posedge CLK) begin
    if (fetch_req) begin
      fetch_addr <= next_pc;
    end
    if (wait_r && fetch_rvalid) begin
      fetch_instr <= rdata;
      fetch_pc    <= fetch_addr;
    end
  end

  assert property (@(posedge CLK) disable iff (!rst_n) fetch_req |-> !fetch_busy);
  assert property (@(posedge CLK) disable iff (!rst_n) redirect |-> !fetch_busy);

endmodule

/* mem_subsystem_top.sv */
// Data-memory side of a two-stage RV32I pipeline
// Load/store unit and fetch unit share one word RAM through an arbiter
// Callers pulse mem_req or fetch_req only while the matching busy is low
`timescale 1ns/1ps

module mem_subsystem_top (
  input  logic                  CLK,
  input  logic                  rst_n,
  input  logic                  mem_req,
  input  rv_mem_pkg::instr_t    instr,
  input  rv_mem_pkg::word_t     rs1_data,
  input  rv_mem_pkg::word_t     rs2_data,
  input  logic                  fetch_req,
  input  logic                  redirect,
  input  rv_mem_pkg::word_t     redirect_addr,
  output logic                  lsu_busy,
  output rv_mem_pkg::word_t     load_data,
  output logic                  load_valid,
  output logic                  store_done,
  output logic                  mal_l,
  output logic                  mal_s,
  output logic                  illegal,
  output logic                  fetch_busy,
  output rv_mem_pkg::word_t     fetch_instr,
  output rv_mem_pkg::word_t     fetch_pc,
  output logic                  fetch_valid
);

  // Load/store side of the arbiter
  logic                          lsu_req;
  logic                          lsu_we;
  rv_mem_pkg::word_t             lsu_addr;
  logic [3:0]                    lsu_byte_en;
  rv_mem_pkg::word_t             lsu_wdata;
  logic                          lsu_gnt;
  logic                          lsu_rvalid;

  // Fetch side of the arbiter
  logic                          fetch_req_bus;
  rv_mem_pkg::word_t             fetch_addr;
  logic                          fetch_gnt;
  logic                          fetch_rvalid;

  // Shared read return and RAM port
  rv_mem_pkg::word_t             rdata;
  logic                          ram_en;
  logic                          ram_we;
  logic [rv_mem_pkg::MEM_AW-1:0] ram_addr;
  logic [3:0]                    ram_byte_en;
  rv_mem_pkg::word_t             ram_wdata;
  rv_mem_pkg::word_t             ram_rdata;

  load_store_unit load_store_unit_i (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .mem_req     (mem_req),
    .instr       (instr),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .lsu_gnt     (lsu_gnt),
    .lsu_rvalid  (lsu_rvalid),
    .rdata       (rdata),
    .lsu_req     (lsu_req),
    .lsu_we      (lsu_we),
    .lsu_addr    (lsu_addr),
    .lsu_byte_en (lsu_byte_en),
    .lsu_wdata   (lsu_wdata),
    .lsu_busy    (lsu_busy),
    .load_data   (load_data),
    .load_valid  (load_valid),
    .store_done  (store_done),
    .mal_l       (mal_l),
    .mal_s       (mal_s),
    .illegal     (illegal)
  );

  fetch_unit fetch_unit_i (
    .CLK           (CLK),
    .rst_n         (rst_n),
    .fetch_req     (fetch_req),
    .redirect      (redirect),
    .redirect_addr (redirect_addr),
    .fetch_gnt     (fetch_gnt),
    .fetch_rvalid  (fetch_rvalid),
    .rdata         (rdata),
    .fetch_req_bus (fetch_req_bus),
    .fetch_addr    (fetch_addr),
    .fetch_busy    (fetch_busy),
    .fetch_instr   (fetch_instr),
    .fetch_pc      (fetch_pc),
    .fetch_valid   (fetch_valid)
  );

  mem_arbiter mem_arbiter_i (
    .CLK          (CLK),
    .rst_n        (rst_n),
    .lsu_req      (lsu_req),
    .lsu_we       (lsu_we),
    .lsu_addr     (lsu_addr),
    .lsu_byte_en  (lsu_byte_en),
    .lsu_wdata    (lsu_wdata),
    .fetch_req    (fetch_req_bus),
    .fetch_addr   (fetch_addr),
    .ram_rdata    (ram_rdata),
    .lsu_gnt      (lsu_gnt),
    .fetch_gnt    (fetch_gnt),
    .lsu_rvalid   (lsu_rvalid),
    .fetch_rvalid (fetch_rvalid),
    .rdata        (rdata),
    .ram_en       (ram_en),
    .ram_we       (ram_we),
    .ram_addr     (ram_addr),
    .ram_byte_en  (ram_byte_en),
    .ram_wdata    (ram_wdata)
  );

  data_ram data_ram_i (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .ram_en      (ram_en),
    .ram_we      (ram_we),
    .ram_addr    (ram_addr),
    .ram_byte_en (ram_byte_en),
    .ram_wdata   (ram_wdata),
    .ram_rdata   (ram_rdata)
  );

endmodule

/* tb_mem_subsystem.sv */
// Self-checking testbench for the RV32I memory subsystem
// A shadow byte array mirrors the RAM, every word is stored before it is read
// Byte addresses stay inside the 1 KiB RAM, so address wrap is not exercised
// Checks live in the concurrent assertions below, the tasks only drive and wait
`timescale 1ns/1ps

module tb_mem_subsystem;

  localparam int TIMEOUT = 50;

  logic               CLK = 1'b0;
  logic               rst_n;
  logic               mem_req;
  rv_mem_pkg::instr_t instr;
  rv_mem_pkg::word_t  rs1_data;
  rv_mem_pkg::word_t  rs2_data;
  logic               fetch_req;
  logic               redirect;
  rv_mem_pkg::word_t  redirect_addr;
  logic               lsu_busy;
  rv_mem_pkg::word_t  load_data;
  logic               load_valid;
  logic               store_done;
  logic               mal_l;
  logic               mal_s;
  logic               illegal;
  logic               fetch_busy;
  rv_mem_pkg::word_t  fetch_instr;
  rv_mem_pkg::word_t  fetch_pc;
  logic               fetch_valid;

  // Reference model and expected values
  logic [7:0]         shadow [1024];
  logic [31:0]        seed;
  rv_mem_pkg::word_t  exp_load;
  rv_mem_pkg::word_t  exp_instr;
  rv_mem_pkg::word_t  exp_pc;
  rv_mem_pkg::word_t  model_pc;
  logic               exp_mal_l;
  logic               exp_mal_s;
  logic               exp_illegal;
  logic               idle_check;
  logic               bad_window;
  logic [7:0]         status;
  int                 value_errs;
  int                 timeout_errs;

  always #5 CLK = ~CLK;

  assign status = {lsu_busy, load_valid, store_done, mal_l, mal_s, illegal,
                   fetch_busy, fetch_valid};

  mem_subsystem_top mem_subsystem_top_i (
    .CLK           (CLK),
    .rst_n         (rst_n),
    .mem_req       (mem_req),
    .instr         (instr),
    .rs1_data      (rs1_data),
    .rs2_data      (rs2_data),
    .fetch_req     (fetch_req),
    .redirect      (redirect),
    .redirect_addr (redirect_addr),
    .lsu_busy      (lsu_busy),
    .load_data     (load_data),
    .load_valid    (load_valid),
    .store_done    (store_done),
    .mal_l         (mal_l),
    .mal_s         (mal_s),
    .illegal       (illegal),
    .fetch_busy    (fetch_busy),
    .fetch_instr   (fetch_instr),
    .fetch_pc      (fetch_pc),
    .fetch_valid   (fetch_valid)
  );

  // Returned data against the shadow memory
  assert property (@(posedge CLK) disable iff (!rst_n) load_valid |-> load_data == exp_load)
    else begin
      value_errs++;
      $display("Fail load_data expected %08h actual %08h", exp_load, $sampled(load_data));
    end
  assert property (@(posedge CLK) disable iff (!rst_n) fetch_valid |-> fetch_instr == exp_instr)
    else begin
      value_errs++;
      $display("Fail fetch_instr expected %08h actual %08h", exp_instr, $sampled(fetch_instr));
    end
  assert property (@(posedge CLK) disable iff (!rst_n) fetch_valid |-> fetch_pc == exp_pc)
    else begin
      value_errs++;
      $display("Fail fetch_pc expected %08h actual %08h", exp_pc, $sampled(fetch_pc));
    end

  // Exception flags exactly one cycle after each request
  assert property (@(posedge CLK) disable iff (!rst_n) mem_req |=> mal_l == exp_mal_l)
    else begin
      value_errs++;
      $display("Fail mal_l expected %0h actual %0h", exp_mal_l, $sampled(mal_l));
    end
  assert property (@(posedge CLK) disable iff (!rst_n) mem_req |=> mal_s == exp_mal_s)
    else begin
      value_errs++;
      $display("Fail mal_s expected %0h actual %0h", exp_mal_s, $sampled(mal_s));
    end
  assert property (@(posedge CLK) disable iff (!rst_n) mem_req |=> illegal == exp_illegal)
    else begin
      value_errs++;
      $display("Fail illegal expected %0h actual %0h", exp_illegal, $sampled(illegal));
    end
  assert property (@(posedge CLK) disable iff (!rst_n)
    (mal_l || mal_s || illegal) |-> $past(mem_req))
    else begin
      value_errs++;
      $display("Exception pulse seen without a request one cycle earlier");
    end

  // Rejected access makes no bus traffic
  assert property (@(posedge CLK) disable iff (!rst_n)
    bad_window |-> !(load_valid || store_done || lsu_busy))
    else begin
      value_errs++;
      $display("Rejected access still raised busy, load_valid or store_done");
    end

  // Quiet after reset
  assert property (@(posedge CLK) disable iff (!rst_n) idle_check |-> status == 8'h00)
    else begin
      value_errs++;
      $display("Fail status outputs expected 00 actual %02h", $sampled(status));
    end

  function automatic logic [31:0] rand_word();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // Small signed offset, -32 to 31
  function automatic logic [11:0] rand_imm();
    logic [31:0] r;
    r = rand_word();
    return {{6{r[5]}}, r[5:0]};
  endfunction

  // rs1 value that makes rs1 + imm land on a
  function automatic logic [31:0] base_for(logic [9:0] a, logic [11:0] imm);
    return {22'd0, a} - {{20{imm[11]}}, imm};
  endfunction

  // I-type load with rs1 = x1, rd = x2
  function automatic logic [31:0] load_word(logic [2:0] f3, logic [11:0] imm);
    return {imm, 5'd1, f3, 5'd2, rv_mem_pkg::OPC_LOAD};
  endfunction

  // S-type store with rs1 = x1, rs2 = x3
  function automatic logic [31:0] store_word(logic [2:0] f3, logic [11:0] imm);
    return {imm[11:5], 5'd3, 5'd1, f3, imm[4:0], rv_mem_pkg::OPC_STORE};
  endfunction

  function automatic logic [31:0] word_at(logic [9:0] a);
    return {shadow[a + 10'd3], shadow[a + 10'd2], shadow[a + 10'd1], shadow[a]};
  endfunction

  // Little-endian value at byte address a, then extended per width
  function automatic logic [31:0] expect_load(logic [9:0] a, logic [2:0] f3);
    logic [7:0] b0;
    logic [7:0] b1;
    b0 = shadow[a];
    b1 = shadow[a + 10'd1];
    case (f3)
      rv_mem_pkg::LB:  return {{24{b0[7]}}, b0};
      rv_mem_pkg::LBU: return {24'd0, b0};
      rv_mem_pkg::LH:  return {{16{b1[7]}}, b1, b0};
      rv_mem_pkg::LHU: return {16'd0, b1, b0};
      default:         return word_at(a);
    endcase
  endfunction

  task automatic step();
    @(posedge CLK);
    #1;
  endtask

  task automatic wait_lsu_idle();
    int n;
    n = 0;
    while (lsu_busy && n < TIMEOUT) begin
      step();
      n++;
    end
    if (lsu_busy) begin
      timeout_errs++;
      $display("Timed out waiting for the load/store unit to go idle");
    end
  endtask

  task automatic wait_fetch_idle();
    int n;
    n = 0;
    while (fetch_busy && n < TIMEOUT) begin
      step();
      n++;
    end
    if (fetch_busy) begin
      timeout_errs++;
      $display("Timed out waiting for the fetch unit to go idle");
    end
  endtask

  // One mem_req pulse
  task automatic send_access(logic [31:0] iw, logic [31:0] rs1, logic [31:0] rs2);
    wait_lsu_idle();
    mem_req  = 1'b1;
    instr    = iw;
    rs1_data = rs1;
    rs2_data = rs2;
    step();
    mem_req  = 1'b0;
  endtask

  task automatic do_store(logic [9:0] a, logic [2:0] f3, logic [31:0] data);
    logic [11:0] imm;
    int          n;
    imm = rand_imm();
    // Shadow takes only the lanes the width covers
    shadow[a] = data[7:0];
    if (f3 != rv_mem_pkg::LB) begin
      shadow[a + 10'd1] = data[15:8];
    end
    if (f3 == rv_mem_pkg::LW) begin
      shadow[a + 10'd2] = data[23:16];
      shadow[a + 10'd3] = data[31:24];
    end
    send_access(store_word(f3, imm), base_for(a, imm), data);
    n = 0;
    while (!store_done && n < TIMEOUT) begin
      step();
      n++;
    end
    if (!store_done) begin
      timeout_errs++;
      $display("Timed out waiting for store_done");
    end
  endtask

  task automatic do_load(logic [9:0] a, logic [2:0] f3);
    logic [11:0] imm;
    int          n;
    imm = rand_imm();
    exp_load = expect_load(a, f3);
    send_access(load_word(f3, imm), base_for(a, imm), rand_word());
    n = 0;
    while (!load_valid && n < TIMEOUT) begin
      step();
      n++;
    end
    if (!load_valid) begin
      timeout_errs++;
      $display("Timed out waiting for load_valid");
    end
    // Keep exp_load until the edge that samples the valid cycle
    step();
  endtask

  // Access that must be refused with one exception pulse
  task automatic do_bad(logic [31:0] iw, logic [31:0] rs1, logic ml, logic ms, logic il);
    exp_mal_l   = ml;
    exp_mal_s   = ms;
    exp_illegal = il;
    bad_window  = 1'b1;
    send_access(iw, rs1, rand_word());
    step();
    step();
    bad_window  = 1'b0;
    exp_mal_l   = 1'b0;
    exp_mal_s   = 1'b0;
    exp_illegal = 1'b0;
  endtask

  task automatic redirect_only(logic [31:0] target);
    wait_fetch_idle();
    redirect      = 1'b1;
    redirect_addr = target;
    step();
    redirect      = 1'b0;
    model_pc      = {target[31:2], 2'b00};
  endtask

  task automatic do_fetch();
    int n;
    wait_fetch_idle();
    exp_pc    = model_pc;
    exp_instr = word_at(model_pc[9:0]);
    fetch_req = 1'b1;
    step();
    fetch_req = 1'b0;
    n = 0;
    while (!fetch_valid && n < TIMEOUT) begin
      step();
      n++;
    end
    if (!fetch_valid) begin
      timeout_errs++;
      $display("Timed out waiting for fetch_valid");
    end
    // Keep exp_pc and exp_instr until the edge that samples the valid cycle
    step();
    model_pc = model_pc + 32'd4;
  endtask

  // Load and redirected fetch in the same cycle, so both contend for the RAM
  task automatic load_and_fetch(logic [9:0] a, logic [2:0] f3, logic [31:0] target);
    logic [11:0] imm;
    logic        got_l;
    logic        got_f;
    int          n;
    wait_lsu_idle();
    wait_fetch_idle();
    imm       = rand_imm();
    exp_load  = expect_load(a, f3);
    model_pc  = {target[31:2], 2'b00};
    exp_pc    = model_pc;
    exp_instr = word_at(model_pc[9:0]);
    mem_req       = 1'b1;
    instr         = load_word(f3, imm);
    rs1_data      = base_for(a, imm);
    rs2_data      = rand_word();
    redirect      = 1'b1;
    redirect_addr = target;
    fetch_req     = 1'b1;
    step();
    mem_req   = 1'b0;
    redirect  = 1'b0;
    fetch_req = 1'b0;
    got_l = 1'b0;
    got_f = 1'b0;
    n = 0;
    while (!(got_l && got_f) && n < TIMEOUT) begin
      step();
      n++;
      if (load_valid) got_l = 1'b1;
      if (fetch_valid) got_f = 1'b1;
    end
    if (!got_l || !got_f) begin
      timeout_errs++;
      $display("Timed out on a contended load and fetch, load %0d fetch %0d", got_l, got_f);
    end
    model_pc = model_pc + 32'd4;
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] iw;
    logic [9:0]  base;
    logic [11:0] imm;
    logic [2:0]  f3;
    logic [1:0]  off;
    seed          = 32'h2fd20dc9;
    rst_n         = 1'b0;
    mem_req       = 1'b0;
    instr         = '0;
    rs1_data      = '0;
    rs2_data      = '0;
    fetch_req     = 1'b0;
    redirect      = 1'b0;
    redirect_addr = '0;
    exp_load      = '0;
    exp_instr     = '0;
    exp_pc        = '0;
    model_pc      = '0;
    exp_mal_l     = 1'b0;
    exp_mal_s     = 1'b0;
    exp_illegal   = 1'b0;
    idle_check    = 1'b0;
    bad_window    = 1'b0;
    value_errs    = 0;
    timeout_errs  = 0;
    repeat (4) @(posedge CLK);
    #1;
    rst_n = 1'b1;

    // Nothing moves without stimulus
    idle_check = 1'b1;
    repeat (8) step();
    idle_check = 1'b0;

    // Fill the whole RAM so no read sees unwritten words
    for (int w = 0; w < 256; w++) begin
      do_store(10'(w * 4), rv_mem_pkg::LW, rand_word());
    end

    // PC comes out of reset at 0
    do_fetch();
    do_fetch();

    // Every store width at every legal offset, checked by a word load
    for (int k = 0; k < 4; k++) begin
      r = rand_word();
      base = {r[9:2], 2'b00};
      for (int o = 0; o < 4; o++) begin
        do_store(base + 10'(o), rv_mem_pkg::LB, rand_word());
        do_load(base, rv_mem_pkg::LW);
      end
      for (int o = 0; o < 4; o += 2) begin
        do_store(base + 10'(o), rv_mem_pkg::LH, rand_word());
        do_load(base, rv_mem_pkg::LW);
      end
      do_store(base, rv_mem_pkg::LW, rand_word());
      do_load(base, rv_mem_pkg::LW);
    end

    // Load widths and extension, first word has both sign cases
    for (int k = 0; k < 4; k++) begin
      r = rand_word();
      base = {r[9:2], 2'b00};
      if (k == 0) begin
        do_store(base, rv_mem_pkg::LW, 32'h80ff7f01);
      end
      for (int o = 0; o < 4; o++) begin
        do_load(base + 10'(o), rv_mem_pkg::LB);
        do_load(base + 10'(o), rv_mem_pkg::LBU);
      end
      for (int o = 0; o < 4; o += 2) begin
        do_load(base + 10'(o), rv_mem_pkg::LH);
        do_load(base + 10'(o), rv_mem_pkg::LHU);
      end
      do_load(base, rv_mem_pkg::LW);
    end

    // Misaligned halves and words
    r = rand_word();
    base = {r[9:2], 2'b00};
    for (int o = 1; o < 4; o++) begin
      imm = rand_imm();
      do_bad(store_word(rv_mem_pkg::LW, imm), base_for(base + 10'(o), imm), 1'b0, 1'b1, 1'b0);
      imm = rand_imm();
      do_bad(load_word(rv_mem_pkg::LW, imm), base_for(base + 10'(o), imm), 1'b1, 1'b0, 1'b0);
    end
    for (int o = 1; o < 4; o += 2) begin
      imm = rand_imm();
      do_bad(store_word(rv_mem_pkg::LH, imm), base_for(base + 10'(o), imm), 1'b0, 1'b1, 1'b0);
      imm = rand_imm();
      do_bad(load_word(rv_mem_pkg::LHU, imm), base_for(base + 10'(o), imm), 1'b1, 1'b0, 1'b0);
    end
    do_load(base, rv_mem_pkg::LW);

    // Unknown opcode, unknown load width, unsigned store
    imm = rand_imm();
    iw = load_word(rv_mem_pkg::LW, imm);
    iw[6:0] = 7'b0110011;
    do_bad(iw, base_for(base, imm), 1'b0, 1'b0, 1'b1);
    imm = rand_imm();
    do_bad(load_word(3'b011, imm), base_for(base, imm), 1'b0, 1'b0, 1'b1);
    imm = rand_imm();
    do_bad(store_word(rv_mem_pkg::LBU, imm), base_for(base, imm), 1'b0, 1'b0, 1'b1);
    do_load(base, rv_mem_pkg::LW);

    // Redirect with junk low bits, then a sequential run
    r = rand_word();
    redirect_only({22'd0, r[9:5], 3'd0, r[1:0]});
    repeat (6) do_fetch();

    // Contended loads and fetches with fresh data
    for (int k = 0; k < 20; k++) begin
      r = rand_word();
      base = {r[9:2], 2'b00};
      do_store(base, rv_mem_pkg::LW, rand_word());
      case (r[12:11])
        2'd0: begin
          f3  = r[13] ? rv_mem_pkg::LBU : rv_mem_pkg::LB;
          off = r[15:14];
        end
        2'd1: begin
          f3  = r[13] ? rv_mem_pkg::LHU : rv_mem_pkg::LH;
          off = {r[14], 1'b0};
        end
        default: begin
          f3  = rv_mem_pkg::LW;
          off = 2'b00;
        end
      endcase
      load_and_fetch(base + {8'd0, off}, f3, {22'd0, r[31:24], r[17:16]});
    end

    step();
    $display("Checks done with %0d value errors and %0d timeouts", value_errs, timeout_errs);
    if (value_errs == 0 && timeout_errs == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* tb.f */
rv_mem_pkg.sv
data_ram.sv
mem_arbiter.sv
load_store_unit.sv
fetch_unit.sv
mem_subsystem_top.sv
tb_mem_subsystem.sv

/* Makefile */
# Verilator flow for the memory subsystem testbench

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module tb_mem_subsystem -f tb.f

sim:
	verilator --binary --timing --assert --top-module tb_mem_subsystem -f tb.f -o sim_tb
	@out="$$(./obj_dir/sim_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST OK$$"

clean:
	rm -rf obj_dir
